// File: include/tcb_consts.svh
//////////////////////////////////////////////////////////////////////
// sizes of the TCB memory subsystem
// include wherever a width, depth or delay is needed
//////////////////////////////////////////////////////////////////////

`ifndef TCB_CONSTS_SVH
`define TCB_CONSTS_SVH

// word address width
`define TCB_ADR_W 6

// data width and byte lanes
`define TCB_DAT_W 32
`define TCB_BEN_W 4

// response delay after a transfer, in cycles
`define TCB_DLY 1

// implemented words, higher addresses answer with an error
`define TCB_MEM_DEPTH 48

// request FIFO entries
`define TCB_QUEUE_DEPTH 4

`endif

// File: verilog/tcb_pkg.sv
//////////////////////////////////////////////////////////////////////
// TCB types shared by the queue, memory, collector and testbench
// refer to them by scoped name, sizes come from the consts header
//////////////////////////////////////////////////////////////////////

`default_nettype none

`include "tcb_consts.svh"

package tcb_pkg;

  //////////////////////////////////////////////////////////////////////
  // data word
  //////////////////////////////////////////////////////////////////////

  // one data word, seen whole or lane by lane
  typedef union packed {
    // whole word view
    logic [`TCB_DAT_W-1:0]      word;
    // byte lane view, lane 0 is the low byte
    logic [`TCB_BEN_W-1:0][7:0] lane;
  } tcb_data_u;

  //////////////////////////////////////////////////////////////////////
  // link and result
  //////////////////////////////////////////////////////////////////////

  // request from manager to subordinate
  typedef struct packed {
    // write enable, low means read
    logic                  wen;
    // word address
    logic [`TCB_ADR_W-1:0] adr;
    // byte enables
    logic [`TCB_BEN_W-1:0] ben;
    // write data
    tcb_data_u             wdt;
  } tcb_req_t;

  // response, TCB_DLY cycles after the transfer
  typedef struct packed {
    // read data
    tcb_data_u rdt;
    // status, 1 is an error
    logic      sts;
  } tcb_rsp_t;

  // result towards the outside
  typedef struct packed {
    logic                  wen;
    logic [`TCB_ADR_W-1:0] adr;
    // read data, disabled lanes zero
    tcb_data_u             rdt;
    logic                  err;
  } tcb_result_t;

endpackage

`default_nettype wire

// File: verilog/tcb_req_queue.sv
//////////////////////////////////////////////////////////////////////
// command FIFO acting as the TCB manager
// takes strobed commands, drives the head entry onto the link
// and holds it there until the subordinate accepts it
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "tcb_consts.svh"

module tcb_req_queue (
  input  wire                tcb,
  input  wire                rst_n,
  // command side
  input  logic               cmd_vld,
  input  tcb_pkg::tcb_req_t  cmd,
  output logic               cmd_rdy,
  // TCB link
  output logic               tcb_vld,
  output tcb_pkg::tcb_req_t  tcb_req,
  input  logic               tcb_rdy
);

  //////////////////////////////////////////////////////////////////////
  // storage and pointers
  //////////////////////////////////////////////////////////////////////

  localparam int unsigned PTR_W = $clog2(`TCB_QUEUE_DEPTH);
  localparam int unsigned CNT_W = $clog2(`TCB_QUEUE_DEPTH + 1);

  localparam logic [PTR_W-1:0] PTR_LAST = PTR_W'(`TCB_QUEUE_DEPTH - 1);
  localparam logic [CNT_W-1:0] CNT_FULL = CNT_W'(`TCB_QUEUE_DEPTH);

  // entries, payload only
  tcb_pkg::tcb_req_t fifo_mem [0:`TCB_QUEUE_DEPTH-1];

  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] cnt;

  logic push;
  logic pop;

  //////////////////////////////////////////////////////////////////////
  // handshakes
  //////////////////////////////////////////////////////////////////////

  // room left
  assign cmd_rdy = (cnt != CNT_FULL);
  // head entry is valid while anything is stored
  assign tcb_vld = (cnt != '0);

  // head drives the link directly, stable through a stall
  assign tcb_req = fifo_mem[rd_ptr];

  assign push = cmd_vld & cmd_rdy;
  // transfer on the link
  assign pop  = tcb_vld & tcb_rdy;

  //////////////////////////////////////////////////////////////////////
  // FIFO control
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge tcb or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      cnt    <= '0;
    end else begin
      // write side, wrap at the last entry
      if (push) begin
        wr_ptr <= (wr_ptr == PTR_LAST) ? '0 : wr_ptr + 1'b1;
      end
      // read side
      if (pop) begin
        rd_ptr <= (rd_ptr == PTR_LAST) ? '0 : rd_ptr + 1'b1;
      end
      // fill level
      case ({push, pop})
        2'b10:   cnt <= cnt + 1'b1;
        2'b01:   cnt <= cnt - 1'b1;
        default: cnt <= cnt;
      endcase
    end
  end

  // entry write, visible on the link one edge later
  always_ff @(posedge tcb) begin
    if (push) begin
      fifo_mem[wr_ptr] <= cmd;
    end
  end

endmodule

`default_nettype wire

// File: verilog/tcb_mem_sub.sv
//////////////////////////////////////////////////////////////////////
// TCB subordinate with a byte enabled register memory
// writes pass a one entry buffer before they commit, reads answer
// TCB_DLY cycles after the transfer, addresses past the end fail
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "tcb_consts.svh"

module tcb_mem_sub (
  input  wire                tcb,
  input  wire                rst_n,
  // TCB link
  input  logic               tcb_vld,
  input  tcb_pkg::tcb_req_t  tcb_req,
  output logic               tcb_rdy,
  output tcb_pkg::tcb_rsp_t  tcb_rsp
);

  // first address with no memory behind it
  localparam logic [`TCB_ADR_W-1:0] ADR_LIM = `TCB_ADR_W'(`TCB_MEM_DEPTH);

  // register memory
  tcb_pkg::tcb_data_u mem [0:`TCB_MEM_DEPTH-1];

  // write buffer
  logic                  wb_vld;
  logic [`TCB_ADR_W-1:0] wb_adr;
  logic [`TCB_BEN_W-1:0] wb_ben;
  tcb_pkg::tcb_data_u    wb_dat;

  logic trn;
  logic in_range;
  logic hazard;

  //////////////////////////////////////////////////////////////////////
  // handshake
  //////////////////////////////////////////////////////////////////////

  assign in_range = (tcb_req.adr < ADR_LIM);

  // read of the word still waiting in the write buffer
  // the buffer empties at the next edge, so the stall lasts one cycle
  assign hazard = tcb_vld & ~tcb_req.wen & wb_vld & (tcb_req.adr == wb_adr);

  assign tcb_rdy = ~hazard;
  assign trn     = tcb_vld & tcb_rdy;

  //////////////////////////////////////////////////////////////////////
  // write buffer
  //////////////////////////////////////////////////////////////////////

  // only in range writes get buffered, others change nothing
  always_ff @(posedge tcb or negedge rst_n) begin
    if (!rst_n) begin
      wb_vld <= 1'b0;
    end else begin
      wb_vld <= trn & tcb_req.wen & in_range;
    end
  end

  always_ff @(posedge tcb) begin
    if (trn & tcb_req.wen) begin
      wb_adr <= tcb_req.adr;
      wb_ben <= tcb_req.ben;
      wb_dat <= tcb_req.wdt;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // memory
  //////////////////////////////////////////////////////////////////////

  // memory starts out as zero
  // buffered write merges lane by lane one cycle after its transfer
  always_ff @(posedge tcb or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < `TCB_MEM_DEPTH; i++) begin
        mem[i] <= '0;
      end
    end else if (wb_vld) begin
      for (int l = 0; l < `TCB_BEN_W; l++) begin
        if (wb_ben[l]) begin
          mem[wb_adr].lane[l] <= wb_dat.lane[l];
        end
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // response
  //////////////////////////////////////////////////////////////////////

  // full word read, the collector does the lane masking
  // writes and errors return zero data
  always_ff @(posedge tcb) begin
    if (trn) begin
      tcb_rsp.sts <= ~in_range;
      if (~tcb_req.wen & in_range) begin
        tcb_rsp.rdt.word <= mem[tcb_req.adr].word;
      end else begin
        tcb_rsp.rdt.word <= '0;
      end
    end
  end

endmodule

`default_nettype wire

// File: verilog/tcb_rsp_collector.sv
//////////////////////////////////////////////////////////////////////
// pairs each TCB response with the request that caused it
// watches the link, delays the request by TCB_DLY and registers a
// result with read data masked to the enabled bytes
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "tcb_consts.svh"

module tcb_rsp_collector (
  input  wire                  tcb,
  input  wire                  rst_n,
  // monitored TCB link
  input  logic                 tcb_vld,
  input  logic                 tcb_rdy,
  input  tcb_pkg::tcb_req_t    tcb_req,
  input  tcb_pkg::tcb_rsp_t    tcb_rsp,
  // results
  output logic                 rsp_vld,
  output tcb_pkg::tcb_result_t rsp
);

  logic trn;

  // transfer flags and requests where index TCB_DLY-1 is due now
  logic [`TCB_DLY-1:0] trn_dly;
  tcb_pkg::tcb_req_t   req_dly [0:`TCB_DLY-1];

  tcb_pkg::tcb_req_t   req_due;
  tcb_pkg::tcb_data_u  rdt_msk;

  assign trn = tcb_vld & tcb_rdy;

  //////////////////////////////////////////////////////////////////////
  // delay line
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge tcb or negedge rst_n) begin
    if (!rst_n) begin
      trn_dly <= '0;
    end else begin
      trn_dly[0] <= trn;
      for (int i = 1; i < `TCB_DLY; i++) begin
        trn_dly[i] <= trn_dly[i-1];
      end
    end
  end

  // requests follow the flags
  always_ff @(posedge tcb) begin
    req_dly[0] <= tcb_req;
    for (int i = 1; i < `TCB_DLY; i++) begin
      req_dly[i] <= req_dly[i-1];
    end
  end

  assign req_due = req_dly[`TCB_DLY-1];

  //////////////////////////////////////////////////////////////////////
  // lane masking
  //////////////////////////////////////////////////////////////////////

  // reads keep enabled lanes only and writes return all zero
  always_comb begin
    rdt_msk.word = tcb_rsp.rdt.word;
    for (int l = 0; l < `TCB_BEN_W; l++) begin
      if (req_due.wen | ~req_due.ben[l]) begin
        rdt_msk.lane[l] = 8'h00;
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // output register
  //////////////////////////////////////////////////////////////////////

  // one strobe per transfer
  always_ff @(posedge tcb or negedge rst_n) begin
    if (!rst_n) begin
      rsp_vld <= 1'b0;
    end else begin
      rsp_vld <= trn_dly[`TCB_DLY-1];
    end
  end

  always_ff @(posedge tcb) begin
    if (trn_dly[`TCB_DLY-1]) begin
      rsp.wen <= req_due.wen;
      rsp.adr <= req_due.adr;
      rsp.rdt <= rdt_msk;
      // status straight from the subordinate
      rsp.err <= tcb_rsp.sts;
    end
  end

endmodule

`default_nettype wire

// File: verilog/tcb_mem_top.sv
//////////////////////////////////////////////////////////////////////
// TCB memory subsystem top level
// command strobes in, one result strobe per command out, in order
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module tcb_mem_top (
  input  wire                  tcb,
  input  wire                  rst_n,
  // commands
  input  logic                 cmd_vld,
  input  tcb_pkg::tcb_req_t    cmd,
  output logic                 cmd_rdy,
  // results
  output logic                 rsp_vld,
  output tcb_pkg::tcb_result_t rsp
);

  //////////////////////////////////////////////////////////////////////
  // internal TCB link
  //////////////////////////////////////////////////////////////////////

  logic              tcb_vld;
  logic              tcb_rdy;
  tcb_pkg::tcb_req_t tcb_req;
  tcb_pkg::tcb_rsp_t tcb_rsp;

  // manager side, buffers the commands
  tcb_req_queue queue_i (
    .tcb     (tcb),
    .rst_n   (rst_n),
    .cmd_vld (cmd_vld),
    .cmd     (cmd),
    .cmd_rdy (cmd_rdy),
    .tcb_vld (tcb_vld),
    .tcb_req (tcb_req),
    .tcb_rdy (tcb_rdy)
  );

  // subordinate with the memory
  tcb_mem_sub sub_i (
    .tcb     (tcb),
    .rst_n   (rst_n),
    .tcb_vld (tcb_vld),
    .tcb_req (tcb_req),
    .tcb_rdy (tcb_rdy),
    .tcb_rsp (tcb_rsp)
  );

  // result side, watches the link
  tcb_rsp_collector collector_i (
    .tcb     (tcb),
    .rst_n   (rst_n),
    .tcb_vld (tcb_vld),
    .tcb_rdy (tcb_rdy),
    .tcb_req (tcb_req),
    .tcb_rsp (tcb_rsp),
    .rsp_vld (rsp_vld),
    .rsp     (rsp)
  );

endmodule

`default_nettype wire

// File: verification/tcb_protocol_assert.sv
//////////////////////////////////////////////////////////////////////
// TCB link protocol checker bound into the subordinate
// watches valid/ready, request stability and known data on the link
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "tcb_consts.svh"

module tcb_protocol_assert (
  input wire               tcb,
  input wire               rst_n,
  input logic              tcb_vld,
  input tcb_pkg::tcb_req_t tcb_req,
  input logic              tcb_rdy,
  input tcb_pkg::tcb_rsp_t tcb_rsp
);

  // failed assertions so far
  int unsigned fail_cnt = 0;

  logic trn;

  assign trn = tcb_vld & tcb_rdy;

  // every enabled lane holds a known byte
  function automatic logic lanes_known(tcb_pkg::tcb_data_u dat, logic [`TCB_BEN_W-1:0] ben);
    logic ok;
    ok = 1'b1;
    for (int l = 0; l < `TCB_BEN_W; l++) begin
      if (ben[l] && $isunknown(dat.lane[l])) begin
        ok = 1'b0;
      end
    end
    return ok;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // handshake
  //////////////////////////////////////////////////////////////////////

  vld_known: assert property (@(posedge tcb) !$isunknown(tcb_vld))
    else begin
      fail_cnt++;
      $error("tcb_vld is unknown");
    end

  // quiet link while in reset
  vld_low_in_reset: assert property (@(posedge tcb) !rst_n |-> !tcb_vld)
    else begin
      fail_cnt++;
      $error("tcb_vld high during reset");
    end

  // first cycle after release
  vld_low_after_reset: assert property (@(posedge tcb) $rose(rst_n) |-> !tcb_vld)
    else begin
      fail_cnt++;
      $error("tcb_vld high right after reset");
    end

  // stall keeps valid and the request as they are
  req_stable: assert property (@(posedge tcb) disable iff (!rst_n)
    (tcb_vld && !tcb_rdy) |=> (tcb_vld && $stable(tcb_req)))
    else begin
      fail_cnt++;
      $error("request changed during a stall");
    end

  //////////////////////////////////////////////////////////////////////
  // data
  //////////////////////////////////////////////////////////////////////

  wdat_known: assert property (@(posedge tcb) disable iff (!rst_n)
    (trn && tcb_req.wen) |-> (!$isunknown(tcb_req.ben) && lanes_known(tcb_req.wdt, tcb_req.ben)))
    else begin
      fail_cnt++;
      $error("unknown write byte at a transfer");
    end

  // response TCB_DLY cycles later with enables from the transfer
  rdat_known: assert property (@(posedge tcb) disable iff (!rst_n)
    (trn && !tcb_req.wen) |-> ##`TCB_DLY
    (!$isunknown(tcb_rsp.sts) && lanes_known(tcb_rsp.rdt, $past(tcb_req.ben, `TCB_DLY))))
    else begin
      fail_cnt++;
      $error("unknown read byte or status in a response");
    end

endmodule

`default_nettype wire

// File: verification/tcb_mem_tb.sv
//////////////////////////////////////////////////////////////////////
// testbench for the TCB memory subsystem
// commands come from the input data file, a reference memory
// predicts every result, the protocol checker rides on the link
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "tcb_consts.svh"

module tcb_mem_tb;

  localparam int MAX_CMD    = 64;
  // commands from here on go back to back
  localparam int BURST_FROM = 16;
  localparam int RST_CYCLES = 8;

  logic                 tcb = 1'b0;
  logic                 rst_n;
  logic                 cmd_vld;
  tcb_pkg::tcb_req_t    cmd;
  logic                 cmd_rdy;
  logic                 rsp_vld;
  tcb_pkg::tcb_result_t rsp;

  // four hex fields per command
  logic [31:0]           stim [0:4*MAX_CMD-1];
  logic [`TCB_DAT_W-1:0] ref_mem [0:`TCB_MEM_DEPTH-1];
  tcb_pkg::tcb_result_t  exp_q [$];

  integer seed;
  int     n_cmd       = 0;
  int     accepted    = 0;
  int     results     = 0;
  int     errors      = 0;
  int     asrt_fails  = 0;
  logic   stim_loaded = 1'b0;
  logic   rdy_dropped = 1'b0;

  // 4 ns period
  always #2 tcb = ~tcb;

  tcb_mem_top dut_i (
    .tcb     (tcb),
    .rst_n   (rst_n),
    .cmd_vld (cmd_vld),
    .cmd     (cmd),
    .cmd_rdy (cmd_rdy),
    .rsp_vld (rsp_vld),
    .rsp     (rsp)
  );

  // protocol checker on the internal link
  bind tcb_mem_sub tcb_protocol_assert prot_chk_i (
    .tcb     (tcb),
    .rst_n   (rst_n),
    .tcb_vld (tcb_vld),
    .tcb_req (tcb_req),
    .tcb_rdy (tcb_rdy),
    .tcb_rsp (tcb_rsp)
  );

  //////////////////////////////////////////////////////////////////////
  // reporting and reference model
  //////////////////////////////////////////////////////////////////////

  task automatic report_mismatch(input string name, input logic [31:0] exp_v,
                                 input logic [31:0] act_v);
    $display("** Error at %0t: %s expected %h, got %h", $realtime, name, exp_v, act_v);
    errors++;
  endtask

  task automatic report_failure(input string what);
    $display("** Error at %0t: %s", $realtime, what);
    errors++;
  endtask

  // commands update the model in order and read bytes outside ben are zero
  task automatic apply_to_model(input tcb_pkg::tcb_req_t c);
    tcb_pkg::tcb_result_t res;
    res          = '0;
    res.wen      = c.wen;
    res.adr      = c.adr;
    res.err      = (int'(c.adr) >= `TCB_MEM_DEPTH);
    if (!res.err) begin
      for (int b = 0; b < `TCB_BEN_W; b++) begin
        if (c.ben[b] && c.wen) begin
          ref_mem[c.adr][8*b +: 8] = c.wdt.word[8*b +: 8];
        end else if (c.ben[b]) begin
          res.rdt.word[8*b +: 8] = ref_mem[c.adr][8*b +: 8];
        end
      end
    end
    exp_q.push_back(res);
  endtask

  task automatic check_result();
    tcb_pkg::tcb_result_t exp_res;
    results++;
    if (exp_q.size() == 0) begin
      report_failure("result strobe with no command outstanding");
    end else begin
      exp_res = exp_q.pop_front();
      if (rsp.wen !== exp_res.wen) report_mismatch("rsp.wen", 32'(exp_res.wen), 32'(rsp.wen));
      if (rsp.adr !== exp_res.adr) report_mismatch("rsp.adr", 32'(exp_res.adr), 32'(rsp.adr));
      if (rsp.rdt.word !== exp_res.rdt.word) begin
        report_mismatch("rsp.rdt", exp_res.rdt.word, rsp.rdt.word);
      end
      if (rsp.err !== exp_res.err) report_mismatch("rsp.err", 32'(exp_res.err), 32'(rsp.err));
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // monitor at mid cycle where outputs are settled
  //////////////////////////////////////////////////////////////////////

  always @(negedge tcb) begin
    if (rst_n === 1'b1) begin
      if (cmd_rdy === 1'b0) rdy_dropped = 1'b1;
      if (rsp_vld !== 1'b0) check_result();
    end else if (rsp_vld !== 1'b0) begin
      report_mismatch("rsp_vld", 32'h0, 32'(rsp_vld));
    end
  end

  //////////////////////////////////////////////////////////////////////
  // stimulus
  //////////////////////////////////////////////////////////////////////

  initial begin
    int                gap;
    tcb_pkg::tcb_req_t c;
    seed    = 32'h21bf4a5a;
    rst_n   = 1'b1;
    cmd_vld = 1'b0;
    cmd     = '0;
    for (int a = 0; a < `TCB_MEM_DEPTH; a++) begin
      ref_mem[a] = '0;
    end
    $readmemh("verification/tcb_mem_input.dat", stim);
    // list ends at the first unfilled entry
    while (n_cmd < MAX_CMD && !$isunknown(stim[4*n_cmd])) begin
      n_cmd++;
    end
    stim_loaded = 1'b1;
    if (n_cmd == 0) report_failure("no commands found in the input file");

    // reset goes low just after time zero
    #1;
    rst_n = 1'b0;
    repeat (RST_CYCLES) @(posedge tcb);
    #0.5 rst_n = 1'b1;

    // idle link after reset
    repeat (5) begin
      @(negedge tcb);
      if (cmd_rdy !== 1'b1) report_mismatch("cmd_rdy", 32'h1, 32'(cmd_rdy));
    end

    for (int i = 0; i < n_cmd; i++) begin
      @(posedge tcb);
      #0.5;
      cmd_vld = 1'b0;
      if (i < BURST_FROM) begin
        gap = $unsigned($random(seed)) % 4;
      end else begin
        gap = 0;
      end
      repeat (gap) begin
        @(posedge tcb);
        #0.5;
      end
      // strobe only into a FIFO with room
      while (cmd_rdy !== 1'b1) begin
        @(posedge tcb);
        #0.5;
      end
      c.wen      = stim[4*i][0];
      c.adr      = stim[4*i+1][`TCB_ADR_W-1:0];
      c.ben      = stim[4*i+2][`TCB_BEN_W-1:0];
      c.wdt.word = stim[4*i+3];
      cmd        = c;
      cmd_vld    = 1'b1;
      apply_to_model(c);
      accepted++;
    end
    @(posedge tcb);
    #0.5;
    cmd_vld = 1'b0;
    cmd     = '0;

    // wait for the outstanding results
    while (exp_q.size() != 0) @(posedge tcb);
    repeat (4) @(posedge tcb);

    if (results != accepted) begin
      report_failure($sformatf("%0d results for %0d commands", results, accepted));
    end
    if (!rdy_dropped) report_failure("cmd_rdy never dropped during the back to back burst");
    asrt_fails = dut_i.sub_i.prot_chk_i.fail_cnt;

    $display("commands %0d, results %0d, errors %0d, assertion failures %0d",
             accepted, results, errors, asrt_fails);
    if (errors == 0 && asrt_fails == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

  // watchdog scaled by the command count
  initial begin
    wait (stim_loaded);
    repeat (n_cmd * 20 + 200) @(posedge tcb);
    $display("watchdog expired with %0d results still missing", exp_q.size());
    $display("Simulation FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// File: verification/tcb_mem_input.dat
// columns: wen adr ben wdt, all hex, one command per line
// first 16 commands get random gaps, the rest run back to back
// full word write and read back
1 05 f 11223344
0 05 f 00000000
// lane merge and partial reads
1 06 f aabbccdd
1 06 5 00ff00ee
0 06 f 00000000
0 06 3 00000000
0 06 c 00000000
// out of range, error and no change
1 30 f deadbeef
0 30 f 00000000
1 3f f 12345678
0 3f f 00000000
// untouched word reads zero, last implemented word
0 00 f 00000000
1 2f f 01020304
0 2f 6 00000000
1 07 f cafef00d
0 07 f 00000000
// burst, read right after write to the same word
1 10 f 10101010
0 10 f 00000000
1 11 3 2222beef
0 11 f 00000000
1 12 f 33333333
0 12 c 00000000
1 13 f 44444444
0 13 f 00000000
1 14 8 55000000
0 14 f 00000000
1 15 f 66666666
0 15 f 00000000
1 10 1 000000aa
0 10 f 00000000

// File: project.f
+incdir+include
verilog/tcb_pkg.sv
verilog/tcb_req_queue.sv
verilog/tcb_mem_sub.sv
verilog/tcb_rsp_collector.sv
verilog/tcb_mem_top.sv
verification/tcb_protocol_assert.sv
verification/tcb_mem_tb.sv

// File: Bender.yml
package:
  name: tcb_mem

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - verilog/tcb_pkg.sv
      - verilog/tcb_req_queue.sv
      - verilog/tcb_mem_sub.sv
      - verilog/tcb_rsp_collector.sv
      - verilog/tcb_mem_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - verification/tcb_protocol_assert.sv
      - verification/tcb_mem_tb.sv
